// File: hw/mips_pkg.sv
package mips_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int inst_w     = 32;
    localparam int half_w     = 16;   // immediate field width
    localparam int opcode_w   = 6;
    localparam int funct_w    = 6;
    localparam int aluop_w    = 8;
    localparam int alusel_w   = 3;

    // instruction field positions
    localparam int op_hi  = 31;
    localparam int op_lo  = 26;
    localparam int rs_hi  = 25;
    localparam int rs_lo  = 21;
    localparam int rt_hi  = 20;
    localparam int rt_lo  = 16;
    localparam int rd_hi  = 15;
    localparam int rd_lo  = 11;
    localparam int sa_hi  = 10;
    localparam int sa_lo  = 6;
    localparam int fn_hi  = 5;
    localparam int fn_lo  = 0;
    localparam int imm_hi = 15;
    localparam int imm_lo = 0;

    localparam logic [data_w-1:0]     zero_word    = '0;
    localparam logic [reg_addr_w-1:0] nop_reg_addr = '0;

    // primary opcode, bits 31:26
    typedef enum logic [opcode_w-1:0] {
        op_special = 6'b000000,
        op_addi    = 6'b001000,
        op_addiu   = 6'b001001,
        op_slti    = 6'b001010,
        op_sltiu   = 6'b001011,
        op_andi    = 6'b001100,
        op_ori     = 6'b001101,
        op_xori    = 6'b001110,
        op_lui     = 6'b001111,
        op_pref    = 6'b110011
    } opcode_e;

    // function field of the special group, bits 5:0
    typedef enum logic [funct_w-1:0] {
        fn_sll  = 6'b000000,
        fn_srl  = 6'b000010,
        fn_sra  = 6'b000011,
        fn_sllv = 6'b000100,
        fn_srlv = 6'b000110,
        fn_srav = 6'b000111,
        fn_sync = 6'b001111,
        fn_add  = 6'b100000,
        fn_addu = 6'b100001,
        fn_sub  = 6'b100010,
        fn_subu = 6'b100011,
        fn_and  = 6'b100100,
        fn_or   = 6'b100101,
        fn_xor  = 6'b100110,
        fn_nor  = 6'b100111,
        fn_slt  = 6'b101010,
        fn_sltu = 6'b101011
    } funct_e;

    typedef enum logic [aluop_w-1:0] {
        alu_nop   = 8'b00000000,
        alu_srl   = 8'b00000010,
        alu_sra   = 8'b00000011,
        alu_add   = 8'b00100000,
        alu_addu  = 8'b00100001,
        alu_sub   = 8'b00100010,
        alu_subu  = 8'b00100011,
        alu_and   = 8'b00100100,
        alu_or    = 8'b00100101,
        alu_xor   = 8'b00100110,
        alu_nor   = 8'b00100111,
        alu_slt   = 8'b00101010,
        alu_sltu  = 8'b00101011,
        alu_addi  = 8'b01010101,
        alu_addiu = 8'b01010110,
        alu_sll   = 8'b01111100
    } aluop_e;

    typedef enum logic [alusel_w-1:0] {
        sel_nop   = 3'b000,
        sel_logic = 3'b001,
        sel_shift = 3'b010,
        sel_arith = 3'b100
    } alusel_e;

endpackage

// File: hw/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic [mips_pkg::inst_w-1:0]     inst_i,
    output logic                            reg1_read_o,
    output logic                            reg2_read_o,
    output logic [mips_pkg::reg_addr_w-1:0] reg1_addr_o,
    output logic [mips_pkg::reg_addr_w-1:0] reg2_addr_o,
    output mips_pkg::aluop_e                aluop_o,
    output mips_pkg::alusel_e               alusel_o,
    output logic [mips_pkg::reg_addr_w-1:0] wd_o,
    output logic                            wreg_o,
    output logic [mips_pkg::data_w-1:0]     imm_o
);
    import mips_pkg::*;

    logic [opcode_w-1:0]    op;
    logic [funct_w-1:0]     fn;
    logic [sa_hi-sa_lo:0]   sa;
    logic [half_w-1:0]      imm16;
    logic [data_w-1:0]      imm_zext;
    logic [data_w-1:0]      imm_sext;
    logic [data_w-1:0]      imm_upper;
    logic [data_w-1:0]      imm_shamt;
    logic                   rr_hit;     // register-register form found
    logic                   ri_hit;     // register-immediate form found

    assign op    = inst_i[op_hi:op_lo];
    assign fn    = inst_i[fn_hi:fn_lo];
    assign sa    = inst_i[sa_hi:sa_lo];
    assign imm16 = inst_i[imm_hi:imm_lo];

    assign imm_zext  = data_w'(imm16);
    assign imm_sext  = {{(data_w-half_w){imm16[half_w-1]}}, imm16};
    assign imm_upper = {imm16, {(data_w-half_w){1'b0}}};
    assign imm_shamt = data_w'(sa);

    // read addresses are always the rs and rt fields
    assign reg1_addr_o = inst_i[rs_hi:rs_lo];
    assign reg2_addr_o = inst_i[rt_hi:rt_lo];

    always_comb begin
        aluop_o     = alu_nop;
        alusel_o    = sel_nop;
        wd_o        = inst_i[rd_hi:rd_lo];
        wreg_o      = 1'b0;
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        imm_o       = zero_word;
        rr_hit      = 1'b0;
        ri_hit      = 1'b0;

        case (op)
            op_special: begin
                if (sa == '0) begin
                    rr_hit = 1'b1; // cleared again below for unknown codes
                    case (fn)
                        fn_or: begin
                            aluop_o  = alu_or;
                            alusel_o = sel_logic;
                        end
                        fn_and: begin
                            aluop_o  = alu_and;
                            alusel_o = sel_logic;
                        end
                        fn_xor: begin
                            aluop_o  = alu_xor;
                            alusel_o = sel_logic;
                        end
                        fn_nor: begin
                            aluop_o  = alu_nor;
                            alusel_o = sel_logic;
                        end
                        fn_sllv: begin
                            aluop_o  = alu_sll;
                            alusel_o = sel_shift;
                        end
                        fn_srlv: begin
                            aluop_o  = alu_srl;
                            alusel_o = sel_shift;
                        end
                        fn_srav: begin
                            aluop_o  = alu_sra;
                            alusel_o = sel_shift;
                        end
                        fn_slt: begin
                            aluop_o  = alu_slt;
                            alusel_o = sel_arith;
                        end
                        fn_sltu: begin
                            aluop_o  = alu_sltu;
                            alusel_o = sel_arith;
                        end
                        fn_add: begin
                            aluop_o  = alu_add;
                            alusel_o = sel_arith;
                        end
                        fn_addu: begin
                            aluop_o  = alu_addu;
                            alusel_o = sel_arith;
                        end
                        fn_sub: begin
                            aluop_o  = alu_sub;
                            alusel_o = sel_arith;
                        end
                        fn_subu: begin
                            aluop_o  = alu_subu;
                            alusel_o = sel_arith;
                        end
                        fn_sync: begin
                            rr_hit      = 1'b0;
                            reg2_read_o = 1'b1; // sync still reads rt
                        end
                        default: begin
                            rr_hit = 1'b0;
                        end
                    endcase
                end
            end
            op_ori: begin
                ri_hit   = 1'b1;
                aluop_o  = alu_or;
                alusel_o = sel_logic;
                imm_o    = imm_zext;
            end
            op_andi: begin
                ri_hit   = 1'b1;
                aluop_o  = alu_and;
                alusel_o = sel_logic;
                imm_o    = imm_zext;
            end
            op_xori: begin
                ri_hit   = 1'b1;
                aluop_o  = alu_xor;
                alusel_o = sel_logic;
                imm_o    = imm_zext;
            end
            op_lui: begin
                ri_hit   = 1'b1;
                aluop_o  = alu_or;  // or with rs, as the ISA puts rs at zero
                alusel_o = sel_logic;
                imm_o    = imm_upper;
            end
            op_slti: begin
                ri_hit   = 1'b1;
                aluop_o  = alu_slt;
                alusel_o = sel_arith;
                imm_o    = imm_sext;
            end
            op_sltiu: begin
                ri_hit   = 1'b1;
                aluop_o  = alu_sltu;
                alusel_o = sel_arith;
                imm_o    = imm_sext;
            end
            op_addi: begin
                ri_hit   = 1'b1;
                aluop_o  = alu_addi;
                alusel_o = sel_arith;
                imm_o    = imm_sext;
            end
            op_addiu: begin
                ri_hit   = 1'b1;
                aluop_o  = alu_addiu;
                alusel_o = sel_arith;
                imm_o    = imm_sext;
            end
            default: begin  // pref and unknown words stay no-op
            end
        endcase

        if (rr_hit) begin
            wreg_o      = 1'b1;
            reg1_read_o = 1'b1;
            reg2_read_o = 1'b1;
        end

        if (ri_hit) begin
            wreg_o      = 1'b1;
            reg1_read_o = 1'b1;
            wd_o        = inst_i[rt_hi:rt_lo];
        end

        // shift by amount, overrides the funct decode above
        if (inst_i[op_hi:rs_lo] == '0) begin
            if (fn == fn_sll || fn == fn_srl || fn == fn_sra) begin
                wreg_o      = 1'b1;
                alusel_o    = sel_shift;
                reg1_read_o = 1'b0;
                reg2_read_o = 1'b1;
                imm_o       = imm_shamt;
                wd_o        = inst_i[rd_hi:rd_lo];
                case (fn)
                    fn_sll:  aluop_o = alu_sll;
                    fn_srl:  aluop_o = alu_srl;
                    default: aluop_o = alu_sra;
                endcase
            end
        end
    end

endmodule

// File: hw/operand_mux.sv
`timescale 1ns/1ps

module operand_mux (
    input  logic                            read_i,
    input  logic [mips_pkg::reg_addr_w-1:0] addr_i,
    input  logic [mips_pkg::data_w-1:0]     reg_data_i,
    input  logic [mips_pkg::data_w-1:0]     imm_i,
    input  logic                            ex_wreg_i,
    input  logic [mips_pkg::reg_addr_w-1:0] ex_wd_i,
    input  logic [mips_pkg::data_w-1:0]     ex_wdata_i,
    input  logic                            mem_wreg_i,
    input  logic [mips_pkg::reg_addr_w-1:0] mem_wd_i,
    input  logic [mips_pkg::data_w-1:0]     mem_wdata_i,
    output logic [mips_pkg::data_w-1:0]     operand_o
);
    import mips_pkg::*;

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = ex_wreg_i && (ex_wd_i == addr_i);
    assign mem_hit = mem_wreg_i && (mem_wd_i == addr_i);

    always_comb begin
        if (!read_i) begin
            operand_o = imm_i;          // port unused, pass immediate
        end else if (ex_hit) begin
            operand_o = ex_wdata_i;     // youngest result wins
        end else if (mem_hit) begin
            operand_o = mem_wdata_i;
        end else begin
            operand_o = reg_data_i;
        end
    end

endmodule

// File: hw/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  mips_pkg::aluop_e                aluop_i,
    input  mips_pkg::alusel_e               alusel_i,
    input  logic [mips_pkg::data_w-1:0]     reg1_i,
    input  logic [mips_pkg::data_w-1:0]     reg2_i,
    input  logic [mips_pkg::reg_addr_w-1:0] wd_i,
    input  logic                            wreg_i,
    output mips_pkg::aluop_e                aluop_o,
    output mips_pkg::alusel_e               alusel_o,
    output logic [mips_pkg::data_w-1:0]     reg1_o,
    output logic [mips_pkg::data_w-1:0]     reg2_o,
    output logic [mips_pkg::reg_addr_w-1:0] wd_o,
    output logic                            wreg_o
);
    import mips_pkg::*;

    // control fields, reset to a bubble
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            aluop_o  <= alu_nop;
            alusel_o <= sel_nop;
            wd_o     <= nop_reg_addr;
            wreg_o   <= 1'b0;
        end else begin
            aluop_o  <= aluop_i;
            alusel_o <= alusel_i;
            wd_o     <= wd_i;
            wreg_o   <= wreg_i;
        end
    end

    // operands also read as zero in a bubble
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            reg1_o <= zero_word;
            reg2_o <= zero_word;
        end else begin
            reg1_o <= reg1_i;
            reg2_o <= reg2_i;
        end
    end

endmodule

// File: hw/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic [mips_pkg::inst_w-1:0]     inst_i,

    // register file
    input  logic [mips_pkg::data_w-1:0]     reg1_data_i,
    input  logic [mips_pkg::data_w-1:0]     reg2_data_i,
    output logic                            reg1_read_o,
    output logic                            reg2_read_o,
    output logic [mips_pkg::reg_addr_w-1:0] reg1_addr_o,
    output logic [mips_pkg::reg_addr_w-1:0] reg2_addr_o,

    // forwards from later stages
    input  logic                            ex_wreg_i,
    input  logic [mips_pkg::reg_addr_w-1:0] ex_wd_i,
    input  logic [mips_pkg::data_w-1:0]     ex_wdata_i,
    input  logic                            mem_wreg_i,
    input  logic [mips_pkg::reg_addr_w-1:0] mem_wd_i,
    input  logic [mips_pkg::data_w-1:0]     mem_wdata_i,

    // to EX, registered
    output mips_pkg::aluop_e                aluop_o,
    output mips_pkg::alusel_e               alusel_o,
    output logic [mips_pkg::data_w-1:0]     reg1_o,
    output logic [mips_pkg::data_w-1:0]     reg2_o,
    output logic [mips_pkg::reg_addr_w-1:0] wd_o,
    output logic                            wreg_o
);
    import mips_pkg::*;

    aluop_e                 dec_aluop;
    alusel_e                dec_alusel;
    logic [reg_addr_w-1:0]  dec_wd;
    logic                   dec_wreg;
    logic [data_w-1:0]      dec_imm;
    logic [data_w-1:0]      op1;
    logic [data_w-1:0]      op2;

    inst_decoder u_dec (
        .inst_i      (inst_i),
        .reg1_read_o (reg1_read_o),
        .reg2_read_o (reg2_read_o),
        .reg1_addr_o (reg1_addr_o),
        .reg2_addr_o (reg2_addr_o),
        .aluop_o     (dec_aluop),
        .alusel_o    (dec_alusel),
        .wd_o        (dec_wd),
        .wreg_o      (dec_wreg),
        .imm_o       (dec_imm)
    );

    operand_mux u_op1 (
        .read_i      (reg1_read_o),
        .addr_i      (reg1_addr_o),
        .reg_data_i  (reg1_data_i),
        .imm_i       (dec_imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (op1)
    );

    operand_mux u_op2 (
        .read_i      (reg2_read_o),
        .addr_i      (reg2_addr_o),
        .reg_data_i  (reg2_data_i),
        .imm_i       (dec_imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (op2)
    );

    id_ex_reg u_id_ex (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .aluop_i  (dec_aluop),
        .alusel_i (dec_alusel),
        .reg1_i   (op1),
        .reg2_i   (op2),
        .wd_i     (dec_wd),
        .wreg_i   (dec_wreg),
        .aluop_o  (aluop_o),
        .alusel_o (alusel_o),
        .reg1_o   (reg1_o),
        .reg2_o   (reg2_o),
        .wd_o     (wd_o),
        .wreg_o   (wreg_o)
    );

endmodule

// File: verification/decode_model.sv
package decode_model;
    import mips_pkg::*;

    // operation of a register-register function code, alu_nop if not kept
    function automatic aluop_e rr_op(input logic [5:0] fn);
        case (fn)
            fn_or:   rr_op = alu_or;
            fn_and:  rr_op = alu_and;
            fn_xor:  rr_op = alu_xor;
            fn_nor:  rr_op = alu_nor;
            fn_sllv: rr_op = alu_sll;
            fn_srlv: rr_op = alu_srl;
            fn_srav: rr_op = alu_sra;
            fn_slt:  rr_op = alu_slt;
            fn_sltu: rr_op = alu_sltu;
            fn_add:  rr_op = alu_add;
            fn_addu: rr_op = alu_addu;
            fn_sub:  rr_op = alu_sub;
            fn_subu: rr_op = alu_subu;
            default: rr_op = alu_nop;
        endcase
    endfunction

    function automatic aluop_e imm_op(input logic [5:0] op);
        case (op)
            op_ori:   imm_op = alu_or;
            op_andi:  imm_op = alu_and;
            op_xori:  imm_op = alu_xor;
            op_lui:   imm_op = alu_or;
            op_slti:  imm_op = alu_slt;
            op_sltiu: imm_op = alu_sltu;
            op_addi:  imm_op = alu_addi;
            op_addiu: imm_op = alu_addiu;
            default:  imm_op = alu_nop;
        endcase
    endfunction

    // result class follows from the operation
    function automatic alusel_e class_of(input aluop_e aluop);
        case (aluop)
            alu_nop:                         class_of = sel_nop;
            alu_or, alu_and, alu_xor, alu_nor: class_of = sel_logic;
            alu_sll, alu_srl, alu_sra:       class_of = sel_shift;
            default:                         class_of = sel_arith;
        endcase
    endfunction

    function automatic void decode(
        input  logic [31:0] inst,
        output logic        rd1,
        output logic        rd2,
        output logic [4:0]  a1,
        output logic [4:0]  a2,
        output aluop_e      aluop,
        output alusel_e     alusel,
        output logic [4:0]  wd,
        output logic        wreg,
        output logic [31:0] imm
    );
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [15:0] imm16;
        op    = inst[31:26];
        fn    = inst[5:0];
        imm16 = inst[15:0];
        a1    = inst[25:21];
        a2    = inst[20:16];
        wd    = inst[15:11];
        rd1   = 1'b0;
        rd2   = 1'b0;
        wreg  = 1'b0;
        aluop = alu_nop;
        imm   = 32'h0;
        if (op == op_special && inst[10:6] == 5'd0) begin
            if (fn == fn_sync) begin
                rd2 = 1'b1;
            end else if (rr_op(fn) != alu_nop) begin
                aluop = rr_op(fn);
                wreg  = 1'b1;
                rd1   = 1'b1;
                rd2   = 1'b1;
            end
        end else if (imm_op(op) != alu_nop) begin
            aluop = imm_op(op);
            wreg  = 1'b1;
            rd1   = 1'b1;
            wd    = inst[20:16];
            if (op == op_lui)
                imm = {imm16, 16'h0};
            else if (op == op_ori || op == op_andi || op == op_xori)
                imm = {16'h0, imm16};
            else
                imm = {{16{imm16[15]}}, imm16};
        end
        // shift by amount needs opcode and rs all zero
        if (inst[31:21] == 11'd0 && (fn == fn_sll || fn == fn_srl || fn == fn_sra)) begin
            aluop = (fn == fn_sll) ? alu_sll : (fn == fn_srl) ? alu_srl : alu_sra;
            wreg  = 1'b1;
            rd1   = 1'b0;
            rd2   = 1'b1;
            imm   = {27'h0, inst[10:6]};
            wd    = inst[15:11];
        end
        alusel = class_of(aluop);
    endfunction

    function automatic logic [31:0] select_operand(
        input logic        rd,
        input logic [4:0]  addr,
        input logic [31:0] reg_data,
        input logic [31:0] imm,
        input logic        ex_wreg,
        input logic [4:0]  ex_wd,
        input logic [31:0] ex_wdata,
        input logic        mem_wreg,
        input logic [4:0]  mem_wd,
        input logic [31:0] mem_wdata
    );
        if (!rd)
            return imm;
        if (ex_wreg && ex_wd == addr)
            return ex_wdata;
        if (mem_wreg && mem_wd == addr)
            return mem_wdata;
        return reg_data;
    endfunction

    // legal kept form from a pick in 0..25, register fields kept small
    function automatic logic [31:0] build_inst(input int unsigned pick, input logic [31:0] rnd);
        funct_e      f;
        opcode_e     o;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        rs = {3'b0, rnd[1:0]};
        rt = {3'b0, rnd[3:2]};
        rd = {3'b0, rnd[5:4]};
        if (pick < 17) begin
            f = f.first();
            repeat (pick) f = f.next();
            if (f == fn_sll || f == fn_srl || f == fn_sra)
                return {6'b0, 5'b0, rt, rd, rnd[10:6], f};
            return {op_special, rs, rt, rd, 5'b0, f};
        end
        o = o.first();
        repeat (pick - 16) o = o.next();    // skips op_special
        return {o, rs, rt, rnd[31:16]};
    endfunction

endpackage

// File: verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic rst_o
);
    localparam time half_period = 4ns;

    initial begin
        clk_o = 1'b0;
        forever #(half_period) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        #1 rst_o = 1'b0;    // released with the other inputs
    end

endmodule

// File: verification/id_stage_assertions.sv
`timescale 1ns/1ps

module id_stage_assertions (
    input logic                            clk_i,
    input logic                            rst_i,
    input mips_pkg::aluop_e                aluop_o,
    input mips_pkg::alusel_e               alusel_o,
    input logic [mips_pkg::data_w-1:0]     reg1_o,
    input logic [mips_pkg::data_w-1:0]     reg2_o,
    input logic [mips_pkg::reg_addr_w-1:0] wd_o,
    input logic                            wreg_o
);
    import mips_pkg::*;

    int fail_count = 0;

    nop_pair: assert property (@(posedge clk_i) disable iff (rst_i)
        (aluop_o == alu_nop) == (alusel_o == sel_nop))
        else begin
            $error("aluop and alusel disagree on no-op");
            fail_count++;
        end

    nop_no_write: assert property (@(posedge clk_i) disable iff (rst_i)
        (aluop_o == alu_nop) |-> !wreg_o)
        else begin
            $error("write enabled on a no-op");
            fail_count++;
        end

    reset_bubble: assert property (@(posedge clk_i) rst_i |=>
        (aluop_o == alu_nop && alusel_o == sel_nop && wd_o == nop_reg_addr
         && !wreg_o && reg1_o == zero_word && reg2_o == zero_word))
        else begin
            $error("registered outputs not a bubble after reset");
            fail_count++;
        end

endmodule

// File: verification/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
    import mips_pkg::*;
    import decode_model::*;

    localparam int n_cycles = 2000;

    logic clk, rst;
    logic [31:0] inst, reg1_data, reg2_data, ex_wdata, mem_wdata;
    logic ex_wreg, mem_wreg;
    logic [4:0] ex_wd, mem_wd;
    logic reg1_read, reg2_read;
    logic [4:0] reg1_addr, reg2_addr;
    aluop_e aluop;
    alusel_e alusel;
    logic [31:0] reg1, reg2;
    logic [4:0] wd;
    logic wreg;

    // model results
    logic m_rd1, m_rd2, m_wreg;
    logic [4:0] m_a1, m_a2, m_wd;
    aluop_e m_aluop;
    alusel_e m_alusel;
    logic [31:0] m_imm;
    // prediction for the registered outputs
    aluop_e p_aluop;
    alusel_e p_alusel;
    logic [31:0] p_reg1, p_reg2;
    logic [4:0] p_wd;
    logic p_wreg, have_pred;
    string name, p_name;
    int seed = 49;
    int errors = 0;
    int checks = 0;

    tb_clock u_clk (.clk_o(clk), .rst_o(rst));

    id_stage uut (
        .clk_i(clk), .rst_i(rst), .inst_i(inst),
        .reg1_data_i(reg1_data), .reg2_data_i(reg2_data),
        .reg1_read_o(reg1_read), .reg2_read_o(reg2_read),
        .reg1_addr_o(reg1_addr), .reg2_addr_o(reg2_addr),
        .ex_wreg_i(ex_wreg), .ex_wd_i(ex_wd), .ex_wdata_i(ex_wdata),
        .mem_wreg_i(mem_wreg), .mem_wd_i(mem_wd), .mem_wdata_i(mem_wdata),
        .aluop_o(aluop), .alusel_o(alusel), .reg1_o(reg1), .reg2_o(reg2),
        .wd_o(wd), .wreg_o(wreg)
    );

    bind id_stage id_stage_assertions u_assert (.*);

    task automatic check(input string test, input string field,
                         input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            $display("Mismatch %s %s: expected %h, actual %h", test, field, exp, act);
            errors++;
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        int unsigned pick;
        r = $random(seed);
        pick = r % 26;
        if (r[31:28] < 4'd3) begin
            inst = $random(seed);
            name = "unrecognised word";
        end else begin
            inst = build_inst(pick, $random(seed));
            name = (pick < 17) ? "register form" : "immediate form";
        end
        r = $random(seed);
        ex_wreg   = r[0];
        mem_wreg  = r[1];
        ex_wd     = {3'b0, r[3:2]};   // small set for frequent matches
        mem_wd    = {3'b0, r[5:4]};
        reg1_data = $random(seed);
        reg2_data = $random(seed);
        ex_wdata  = $random(seed);
        mem_wdata = $random(seed);
    endtask

    task automatic check_registered();
        check(p_name, "aluop", 32'(p_aluop), 32'(aluop));
        check(p_name, "alusel", 32'(p_alusel), 32'(alusel));
        check(p_name, "reg1", p_reg1, reg1);
        check(p_name, "reg2", p_reg2, reg2);
        check(p_name, "wd", 32'(p_wd), 32'(wd));
        check(p_name, "wreg", 32'(p_wreg), 32'(wreg));
    endtask

    task automatic predict_and_check_ports();
        decode(inst, m_rd1, m_rd2, m_a1, m_a2, m_aluop, m_alusel, m_wd, m_wreg, m_imm);
        check(name, "reg1_read", 32'(m_rd1), 32'(reg1_read));
        check(name, "reg2_read", 32'(m_rd2), 32'(reg2_read));
        check(name, "reg1_addr", 32'(m_a1), 32'(reg1_addr));
        check(name, "reg2_addr", 32'(m_a2), 32'(reg2_addr));
        if (rst) begin
            p_aluop  = alu_nop;
            p_alusel = sel_nop;
            p_reg1   = 32'h0;
            p_reg2   = 32'h0;
            p_wd     = 5'd0;
            p_wreg   = 1'b0;
            p_name   = "reset";
        end else begin
            p_aluop  = m_aluop;
            p_alusel = m_alusel;
            p_reg1   = select_operand(m_rd1, m_a1, reg1_data, m_imm, ex_wreg, ex_wd,
                                      ex_wdata, mem_wreg, mem_wd, mem_wdata);
            p_reg2   = select_operand(m_rd2, m_a2, reg2_data, m_imm, ex_wreg, ex_wd,
                                      ex_wdata, mem_wreg, mem_wd, mem_wdata);
            p_wd     = m_wd;
            p_wreg   = m_wreg;
            p_name   = name;
        end
        have_pred = 1'b1;
    endtask

    initial begin
        inst = 32'h0;
        reg1_data = 32'h0;
        reg2_data = 32'h0;
        ex_wdata = 32'h0;
        mem_wdata = 32'h0;
        ex_wreg = 1'b0;
        mem_wreg = 1'b0;
        ex_wd = 5'd0;
        mem_wd = 5'd0;
        have_pred = 1'b0;
        for (int i = 0; i < n_cycles; i++) begin
            @(posedge clk);
            #1;
            if (have_pred)
                check_registered();
            drive_inputs();
            #1;
            predict_and_check_ports();
        end
        @(posedge clk);
        #1;
        check_registered();
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, uut.u_assert.fail_count);
        if (errors == 0 && uut.u_assert.fail_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    initial begin
        #((n_cycles + 100) * 8ns + 50ns);
        $display("timeout: the test loop did not complete in time");
        $display("Test failed");
        $finish;
    end

endmodule

// File: project.f
hw/mips_pkg.sv
hw/inst_decoder.sv
hw/operand_mux.sv
hw/id_ex_reg.sv
hw/id_stage.sv
verification/decode_model.sv
verification/tb_clock.sv
verification/id_stage_assertions.sv
verification/tb_id_stage.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_id_stage \
    -o sim_id_stage > build.log 2>&1 \
    && ./obj_dir/sim_id_stage > sim.log 2>&1 \
    || { echo "build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }

grep -q "^Test passed$" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
